/* hdl/fpFormatPkg.sv */
// Single precision format definitions shared by the divider stages and the testbench.
// Mantissas carry the hidden bit. The result exponent is kept wider than the input
// exponent so that under- and overflow can be sorted out by a later normalizer.

`default_nettype none

package fpFormatPkg;

  //////////////////////////////////////////////////
  // format widths

  localparam int MantWidth = 24;  // incl. hidden bit
  localparam int ExpWidth  = 8;
  localparam int ExpBias   = 127;

  //////////////////////////////////////////////////
  // vector types

  typedef logic [MantWidth-1:0] mantT;  // normalized, bit 23 set
  typedef logic [ExpWidth-1:0]  expT;   // biased exponent

  // pre-normalized result exponent, two's complement, wraps in 10 bits
  typedef logic [ExpWidth+1:0]  expResT;

endpackage

`default_nettype wire

/* hdl/divCtrlPkg.sv */
// Iteration constants and types of the non-restoring divider.
// The iteration cell itself lives here as a function, so the execute stage and
// the result stage evaluate exactly the same add/subtract step.

`default_nettype none

package divCtrlPkg;

  localparam int CellsPerCycle = 4;
  localparam int IterCycles    = 6;  // 6 x 4 = 24 quotient bits

  typedef logic [fpFormatPkg::MantWidth:0] remT;  // sign bit + mantissa
  typedef logic [2:0] iterCntT;

  typedef enum logic [1:0] {Idle, Iterate, Hand} iterStateT;

  // one non-restoring step, returns {carry, sum}
  // carry is the quotient bit, sub also acts as carry in of the two's complement
  function automatic logic [fpFormatPkg::MantWidth+1:0] nrCell(remT a,
      fpFormatPkg::mantT den, logic sub);
    remT denOp;
    denOp = sub ? ~{1'b0, den} : {1'b0, den};
    return a + denOp + sub;
  endfunction

endpackage

`default_nettype wire

/* hdl/divStageIf.sv */
// Stage-to-stage buses of the divider, both with a valid/ready handshake.
// divOpIf carries a decoded operand pair from decode to execute, divRemIf the
// raw quotient and final remainder from execute to the result stage.

`timescale 1ns/1ns
`default_nettype none

interface divOpIf;

  logic                  valid;
  logic                  ready;
  fpFormatPkg::mantT     num;
  fpFormatPkg::mantT     den;
  fpFormatPkg::expResT   exp;  // already biased

  modport source (output valid, input ready, output num, output den, output exp);
  modport sink   (input valid, output ready, input num, input den, input exp);

endinterface

interface divRemIf;

  logic                  valid;
  logic                  ready;
  fpFormatPkg::mantT     quot;
  divCtrlPkg::remT       rem;
  logic                  lastBit;  // selects add or sub for the extra step
  fpFormatPkg::mantT     den;
  fpFormatPkg::expResT   exp;

  modport source (output valid, input ready, output quot, output rem, output lastBit,
                  output den, output exp);
  modport sink   (input valid, output ready, input quot, input rem, input lastBit,
                  input den, input exp);

endinterface

`default_nettype wire

/* hdl/divDecode.sv */
// Intake stage of the divider. Holds one operand pair and computes the biased
// result exponent on intake. The entry is offered to the execute stage one clock
// after acceptance and can be refilled in the cycle it is handed over.

`timescale 1ns/1ns
`default_nettype none

module divDecode (
  input  logic                Clk_CI,
  input  logic                Rst_RBI,
  input  logic                inValid,
  output logic                inReady,
  input  fpFormatPkg::mantT   numMant,
  input  fpFormatPkg::mantT   denMant,
  input  fpFormatPkg::expT    numExp,
  input  fpFormatPkg::expT    denExp,
  divOpIf.source              op
);

  logic                  full;
  logic                  takeIn;
  fpFormatPkg::mantT     numReg;
  fpFormatPkg::mantT     denReg;
  fpFormatPkg::expResT   expReg;

  // free, or drained by execute in this very cycle
  assign inReady = ~full | op.ready;
  assign takeIn  = inValid & inReady;

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      full <= 1'b0;
    end
    else if (takeIn)
    begin
      full <= 1'b1;
    end
    else if (op.ready)
    begin
      full <= 1'b0;  // handed over
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (takeIn)
    begin
      numReg <= numMant;
      denReg <= denMant;
      // numExp - denExp + bias, wraps in 10 bits
      expReg <= fpFormatPkg::expResT'(numExp) - fpFormatPkg::expResT'(denExp)
                + fpFormatPkg::expResT'(fpFormatPkg::ExpBias);
    end
  end

  assign op.valid = full;
  assign op.num   = numReg;
  assign op.den   = denReg;
  assign op.exp   = expReg;

endmodule

`default_nettype wire

/* hdl/divIterate.sv */
// Execute stage of the divider. Four non-restoring cells are chained per clock,
// so a division takes IterCycles clocks after the operand pair is taken. The
// result then waits in Hand until the result stage accepts it. A new pair is
// only taken in Idle.

`timescale 1ns/1ns
`default_nettype none

module divIterate (
  input  logic   Clk_CI,
  input  logic   Rst_RBI,
  divOpIf.sink   op,
  divRemIf.source rem
);

  localparam int MantW = fpFormatPkg::MantWidth;
  localparam int Cells = divCtrlPkg::CellsPerCycle;

  divCtrlPkg::iterStateT  iterState;
  divCtrlPkg::iterCntT    iterCnt;
  logic                   firstStep;
  logic                   lastCycle;

  divCtrlPkg::remT        remReg;   // {0,num} right after load
  fpFormatPkg::mantT      quotReg;
  fpFormatPkg::mantT      denReg;
  fpFormatPkg::expResT    expReg;

  divCtrlPkg::remT        cellRem;
  logic [Cells-1:0]       cellBits;

  assign firstStep = (iterState == divCtrlPkg::Iterate) && (iterCnt == '0);
  assign lastCycle = iterCnt == divCtrlPkg::iterCntT'(divCtrlPkg::IterCycles - 1);

  //////////////////////////////////////////////////
  // iteration cells

  always_comb
  begin
    divCtrlPkg::remT         cellA;
    logic [MantW+1:0]        cellOut;
    logic                    cellSub;
    cellRem = remReg;
    cellSub = quotReg[0];  // previous q bit
    for (int i = 0; i < Cells; i++)
    begin
      if (i == 0 && firstStep)
      begin
        cellA   = remReg;  // plain num - den, no shift
        cellSub = 1'b1;
      end
      else
      begin
        cellA = {cellRem[MantW-1:0], 1'b0};
      end
      cellOut = divCtrlPkg::nrCell(cellA, denReg, cellSub);
      cellRem = cellOut[MantW:0];
      cellSub = cellOut[MantW+1];  // carry = next quotient bit
      cellBits[Cells-1-i] = cellSub;
    end
  end

  //////////////////////////////////////////////////
  // control FSM

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      iterState <= divCtrlPkg::Idle;
      iterCnt   <= '0;
    end
    else
    begin
      case (iterState)
        divCtrlPkg::Idle:
        begin
          if (op.valid)
          begin
            iterState <= divCtrlPkg::Iterate;
            iterCnt   <= '0;
          end
        end
        divCtrlPkg::Iterate:
        begin
          if (lastCycle)
          begin
            iterState <= divCtrlPkg::Hand;
            iterCnt   <= '0;
          end
          else
          begin
            iterCnt <= iterCnt + 1'b1;
          end
        end
        divCtrlPkg::Hand:
        begin
          if (rem.ready)
          begin
            iterState <= divCtrlPkg::Idle;
          end
        end
        default:
        begin
          iterState <= divCtrlPkg::Idle;
        end
      endcase
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (op.valid && op.ready)
    begin
      remReg <= {1'b0, op.num};
      denReg <= op.den;
      expReg <= op.exp;
    end
    else if (iterState == divCtrlPkg::Iterate)
    begin
      remReg  <= cellRem;
      quotReg <= {quotReg[MantW-Cells-1:0], cellBits};  // msb first
    end
  end

  assign op.ready    = iterState == divCtrlPkg::Idle;
  assign rem.valid   = iterState == divCtrlPkg::Hand;
  assign rem.quot    = quotReg;
  assign rem.rem     = remReg;
  assign rem.lastBit = quotReg[0];
  assign rem.den     = denReg;
  assign rem.exp     = expReg;

endmodule

`default_nettype wire

/* hdl/divRound.sv */
// Result stage of the divider. One more non-restoring step on the final
// remainder gives the 25th quotient bit, which is added to the quotient as
// rounding. A sum that carries out of 24 bits leaves the quotient unrounded.
// The result is held until the consumer takes it.

`timescale 1ns/1ns
`default_nettype none

module divRound (
  input  logic                  Clk_CI,
  input  logic                  Rst_RBI,
  divRemIf.sink                 rem,
  output logic                  outValid,
  input  logic                  outReady,
  output fpFormatPkg::mantT     quotMant,
  output fpFormatPkg::expResT   quotExp
);

  localparam int MantW = fpFormatPkg::MantWidth;

  logic [MantW+1:0]     extraStep;
  logic                 extraBit;
  logic [MantW:0]       quotInc;
  fpFormatPkg::mantT    quotRnd;
  logic                 takeRes;

  // extra step, same cell as in execute
  assign extraStep = divCtrlPkg::nrCell({rem.rem[MantW-1:0], 1'b0}, rem.den, rem.lastBit);
  assign extraBit  = extraStep[MantW+1];

  assign quotInc = {1'b0, rem.quot} + extraBit;
  assign quotRnd = quotInc[MantW] ? rem.quot : quotInc[MantW-1:0];  // overflow keeps q

  // empty, or drained in the same cycle
  assign rem.ready = ~outValid | outReady;
  assign takeRes   = rem.valid & rem.ready;

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      outValid <= 1'b0;
    end
    else if (takeRes)
    begin
      outValid <= 1'b1;
    end
    else if (outReady)
    begin
      outValid <= 1'b0;
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (takeRes)
    begin
      quotMant <= quotRnd;
      quotExp  <= rem.exp;
    end
  end

endmodule

`default_nettype wire

/* hdl/mantDivTop.sv */
// Top level of the mantissa and exponent divider. Operand pairs enter through
// inValid/inReady, results leave through outValid/outReady. Decode, execute
// and result stage are joined by the two stage buses. Up to three divisions
// are in flight at once.

`timescale 1ns/1ns
`default_nettype none

module mantDivTop (
  input  logic                  Clk_CI,
  input  logic                  Rst_RBI,
  input  logic                  inValid,
  output logic                  inReady,
  input  fpFormatPkg::mantT     numMant,
  input  fpFormatPkg::mantT     denMant,
  input  fpFormatPkg::expT      numExp,
  input  fpFormatPkg::expT      denExp,
  output logic                  outValid,
  input  logic                  outReady,
  output fpFormatPkg::mantT     quotMant,
  output fpFormatPkg::expResT   quotExp
);

  divOpIf  opBus ();   // decode -> execute
  divRemIf remBus ();  // execute -> result

  divDecode iDecode (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .inValid (inValid),
    .inReady (inReady),
    .numMant (numMant),
    .denMant (denMant),
    .numExp  (numExp),
    .denExp  (denExp),
    .op      (opBus.source)
  );

  divIterate iIterate (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .op      (opBus.sink),
    .rem     (remBus.source)
  );

  divRound iRound (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .rem      (remBus.sink),
    .outValid (outValid),
    .outReady (outReady),
    .quotMant (quotMant),
    .quotExp  (quotExp)
  );

endmodule

`default_nettype wire

/* verif/mantDivTop_chk.sv */
// Handshake assertions on the divider top level.
// Bound into every mantDivTop instance.

`timescale 1ns/1ns
`default_nettype none

module mantDivTopChk (
  input logic                  Clk_CI,
  input logic                  Rst_RBI,
  input logic                  inReady,
  input logic                  outValid,
  input logic                  outReady,
  input fpFormatPkg::mantT     quotMant,
  input fpFormatPkg::expResT   quotExp
);

  // result held until taken
  outHeld: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    outValid && !outReady |=> outValid)
    else $error("outValid dropped before outReady was seen");

  outStable: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    outValid && !outReady |=> $stable(quotMant) && $stable(quotExp))
    else $error("result changed while the consumer stalled");

  // first cycle out of reset
  readyAfterReset: assert property (@(posedge Clk_CI) $rose(Rst_RBI) |-> inReady)
    else $error("inReady low in the first cycle after reset");

endmodule

bind mantDivTop mantDivTopChk iChk (
  .Clk_CI   (Clk_CI),
  .Rst_RBI  (Rst_RBI),
  .inReady  (inReady),
  .outValid (outValid),
  .outReady (outReady),
  .quotMant (quotMant),
  .quotExp  (quotExp)
);

`default_nettype wire

/* verif/mantDivTb.sv */
// Testbench of the mantissa and exponent divider.
// Sends operand pairs through the input handshake and checks every result
// against a reference model, in order. Covers the reset state, directed values,
// random operands with and without back-pressure, and the unstalled latency.
// Stops at the first error.

`timescale 1ns/1ns
`default_nettype none

module mantDivTb;

  localparam int ClkPeriod  = 100;
  localparam int NumRandom  = 200;
  localparam int WaitCycles = 500;  // per wait
  localparam int Latency    = 8;
  localparam logic [31:0] Seed = 32'h087149ac;

  logic                  Clk_CI;
  logic                  Rst_RBI;
  logic                  inValid;
  logic                  inReady;
  fpFormatPkg::mantT     numMant;
  fpFormatPkg::mantT     denMant;
  fpFormatPkg::expT      numExp;
  fpFormatPkg::expT      denExp;
  logic                  outValid;
  logic                  outReady;
  fpFormatPkg::mantT     quotMant;
  fpFormatPkg::expResT   quotExp;

  fpFormatPkg::mantT     expMantQ[$];  // expected results in arrival order
  fpFormatPkg::expResT   expExpQ[$];
  logic [31:0]           rngState;     // operands
  logic [31:0]           readyState;   // outReady pattern
  string                 testName;
  logic                  randomReady;
  logic                  sawStall;
  int                    sent;
  int                    received;

  mantDivTop dut (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .inValid  (inValid),
    .inReady  (inReady),
    .numMant  (numMant),
    .denMant  (denMant),
    .numExp   (numExp),
    .denExp   (denExp),
    .outValid (outValid),
    .outReady (outReady),
    .quotMant (quotMant),
    .quotExp  (quotExp)
  );

  initial
  begin
    Clk_CI = 1'b0;
    forever
    begin
      #(ClkPeriod / 2) Clk_CI = ~Clk_CI;
    end
  end

  //////////////////////////////////////////////////
  // reference model and random source

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // q25 = floor(num * 2^24 / den)
  // its low bit rounds q unless q is all ones
  function automatic fpFormatPkg::mantT refMant(fpFormatPkg::mantT num,
      fpFormatPkg::mantT den);
    logic [47:0]        dividend;
    logic [47:0]        q25;
    fpFormatPkg::mantT  q;
    dividend = {num, 24'h000000};
    q25      = dividend / {24'h000000, den};
    q        = q25[24:1];
    if (q25[0] && (q != '1))
    begin
      q = q + 1'b1;
    end
    return q;
  endfunction

  function automatic fpFormatPkg::expResT refExp(fpFormatPkg::expT nExp,
      fpFormatPkg::expT dExp);
    int e;
    e = int'(nExp) - int'(dExp) + fpFormatPkg::ExpBias;
    return fpFormatPkg::expResT'(e);  // keeps the low 10 bits
  endfunction

  //////////////////////////////////////////////////
  // checks

  task automatic failRun(string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkMant(fpFormatPkg::mantT expVal, fpFormatPkg::mantT actVal);
    if (actVal !== expVal)
    begin
      failRun($sformatf("mismatch %s quotMant expected %h actual %h",
                        testName, expVal, actVal));
    end
  endtask

  task automatic checkExp(fpFormatPkg::expResT expVal, fpFormatPkg::expResT actVal);
    if (actVal !== expVal)
    begin
      failRun($sformatf("mismatch %s quotExp expected %h actual %h",
                        testName, expVal, actVal));
    end
  endtask

  task automatic checkBit(string what, logic expVal, logic actVal);
    if (actVal !== expVal)
    begin
      failRun($sformatf("mismatch %s %s expected %b actual %b",
                        testName, what, expVal, actVal));
    end
  endtask

  task automatic checkLatency(int expVal, int actVal);
    if (actVal != expVal)
    begin
      failRun($sformatf("mismatch %s latency expected %0d actual %0d",
                        testName, expVal, actVal));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus tasks called on a falling edge

  task automatic issueOp(fpFormatPkg::mantT num, fpFormatPkg::mantT den,
      fpFormatPkg::expT nExp, fpFormatPkg::expT dExp);
    int waited;
    waited  = 0;
    inValid = 1'b1;
    numMant = num;
    denMant = den;
    numExp  = nExp;
    denExp  = dExp;
    while (!inReady)  // ready depends on state only
    begin
      sawStall = 1'b1;
      @(negedge Clk_CI);
      waited++;
      if (waited > WaitCycles)
      begin
        failRun("timeout: the DUT never accepted the operand pair");
      end
    end
    expMantQ.push_back(refMant(num, den));  // transfer on next rising edge
    expExpQ.push_back(refExp(nExp, dExp));
    sent++;
    @(negedge Clk_CI);
    inValid = 1'b0;
  endtask

  task automatic issueRandom();
    fpFormatPkg::mantT num;
    fpFormatPkg::mantT den;
    rngState = xorshift(rngState);
    num      = {1'b1, rngState[22:0]};
    rngState = xorshift(rngState);
    den      = {1'b1, rngState[22:0]};
    rngState = xorshift(rngState);
    issueOp(num, den, rngState[7:0], rngState[15:8]);
  endtask

  task automatic waitDrained();
    int waited;
    waited = 0;
    while ((expMantQ.size() != 0) || outValid)
    begin
      @(negedge Clk_CI);
      waited++;
      if (waited > WaitCycles * 8)
      begin
        failRun("timeout: results did not drain from the DUT");
      end
    end
  endtask

  //////////////////////////////////////////////////
  // compare process that also drives outReady

  initial
  begin
    fpFormatPkg::mantT    wantMant;
    fpFormatPkg::expResT  wantExp;
    forever
    begin
      @(negedge Clk_CI);
      readyState = xorshift(readyState);
      outReady   = randomReady ? readyState[0] : 1'b1;
      if (outValid && outReady)  // transfer on next rising edge
      begin
        if (expMantQ.size() == 0)
        begin
          failRun("the DUT delivered a result with no operand pair pending");
        end
        else
        begin
          wantMant = expMantQ.pop_front();
          wantExp  = expExpQ.pop_front();
          checkMant(wantMant, quotMant);
          checkExp(wantExp, quotExp);
          received++;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // test sequence

  initial
  begin
    int n;
    inValid     = 1'b0;
    numMant     = '0;
    denMant     = '0;
    numExp      = '0;
    denExp      = '0;
    outReady    = 1'b0;
    randomReady = 1'b0;
    sawStall    = 1'b0;
    sent        = 0;
    received    = 0;
    rngState    = Seed;
    readyState  = ~Seed;
    testName    = "reset";
    Rst_RBI     = 1'b0;
    repeat (3) @(posedge Clk_CI);
    @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    checkBit("outValid", 1'b0, outValid);
    checkBit("inReady", 1'b1, inReady);

    testName = "directed";
    issueOp(24'h800000, 24'h800000, 8'd127, 8'd127);  // gives 2^23
    issueOp(24'hffffff, 24'h800000, 8'd0, 8'd254);    // near max quotient and exp wrap
    issueOp(24'hc00000, 24'hc00000, 8'd200, 8'd100);
    issueOp(24'h800000, 24'hffffff, 8'd1, 8'd1);      // smallest quotient
    waitDrained();

    testName = "random";
    for (int i = 0; i < NumRandom; i++)
    begin
      issueRandom();
    end
    waitDrained();

    // pipeline is empty here
    testName = "latency";
    issueRandom();
    n = 0;  // rising edges after the transfer edge
    while (!outValid)
    begin
      @(negedge Clk_CI);
      n++;
      if (n > WaitCycles)
      begin
        failRun("timeout: outValid never rose after a single operation");
      end
    end
    checkLatency(Latency, n);
    waitDrained();

    testName    = "backpressure";
    randomReady = 1'b1;
    sawStall    = 1'b0;
    for (int i = 0; i < NumRandom; i++)
    begin
      issueRandom();
    end
    waitDrained();
    randomReady = 1'b0;
    if (!sawStall)
    begin
      failRun("inReady never fell while the pipeline was full");
    end

    if ((received == sent) && (expMantQ.size() == 0))
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
    begin
      failRun($sformatf("sent %0d operand pairs but received %0d results",
                        sent, received));
    end
  end

endmodule

`default_nettype wire

/* files.f */
hdl/fpFormatPkg.sv
hdl/divCtrlPkg.sv
hdl/divStageIf.sv
hdl/divDecode.sv
hdl/divIterate.sv
hdl/divRound.sv
hdl/mantDivTop.sv
verif/mantDivTop_chk.sv
verif/mantDivTb.sv

/* Makefile */
# Verilator build and run of the divider testbench.
# The simulation exit status carries pass or fail.

TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= mantDivTb
FILELIST ?= files.f
BUILDDIR ?= obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP)

clean:
	rm -rf $(BUILDDIR)
